/* verilog/core_msg_macros.svh */
`ifndef CORE_MSG_MACROS_SVH
`define CORE_MSG_MACROS_SVH

// Cores attached to the message path
// Must stay a power of two so the core index wraps naturally
`define CORE_COUNT 16

// Data memory per core, in bytes
// The message address field is sized from this
`define DMEM_SIZE_BYTES 32768

// Message kind field
`define MSG_TYPE_WIDTH 4

// Written data carried by each message
`define MSG_DATA_WIDTH 32

`endif

/* verilog/core_msg_pkg.sv */
`default_nettype none

`include "core_msg_macros.svh"

package core_msg_pkg;

  // Widths derived from the core count and memory size
  localparam int CORE_ID_WIDTH   = $clog2(`CORE_COUNT);
  localparam int DMEM_ADDR_WIDTH = $clog2(`DMEM_SIZE_BYTES);

  // Index of one core on the message path
  typedef logic [CORE_ID_WIDTH-1:0] core_id_t;

  // One bit per core, bit i belongs to core i
  typedef logic [`CORE_COUNT-1:0] core_mask_t;

  // Byte address inside a core's data memory
  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

  // Core-to-core message
  // Field order matches the flat layout the cores drive: kind on top
  typedef struct packed {
    logic [`MSG_TYPE_WIDTH-1:0] kind;
    dmem_addr_t                 addr;
    logic [`MSG_DATA_WIDTH-1:0] data;
  } core_msg_t;

  // Flat message width for the top-level vectors
  localparam int MSG_WIDTH = $bits(core_msg_t);

endpackage

`default_nettype wire

/* verilog/msg_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_msg_macros.svh"

module msg_arbiter
(
  input  wire                                core_clk,
  input  wire                                core_rst,

  // Sender side, one valid/ready pair per core
  input  wire  core_msg_pkg::core_mask_t     send_valid,
  input  wire  core_msg_pkg::core_msg_t      send_msg [`CORE_COUNT],
  output logic [`CORE_COUNT-1:0]             send_ready,

  // Merged stream towards the broadcast stage
  output logic                               merged_valid,
  output core_msg_pkg::core_msg_t            merged_msg,
  output core_msg_pkg::core_id_t             merged_sender
);

  import core_msg_pkg::*;

  // Core granted most recently
  core_id_t   last_grant;

  // Cores whose index lies above the last grant
  core_mask_t upper_mask;

  // Requests split into the wrapped and unwrapped search halves
  core_mask_t upper_req;
  logic       upper_any;

  // Grant decision for the current cycle
  core_id_t   grant_idx;
  logic       grant_any;
  core_mask_t grant_onehot;

  // Transfer taken on the grant edge, one cycle ahead of the merged outputs
  logic       grant_valid;
  core_msg_t  grant_msg;
  core_id_t   grant_sender;

  // Lowest set bit of a request vector
  // Returns zero when nothing is set, callers check for that separately
  function automatic core_id_t lowest_set(input core_mask_t req);
    core_id_t idx;
    idx = '0;
    for (int i = `CORE_COUNT - 1; i >= 0; i--)
    begin
      if (req[i])
      begin
        idx = core_id_t'(i);
      end
    end
    return idx;
  endfunction

  // Mask of the cores searched first in round-robin order
  always_comb
  begin
    upper_mask = '0;
    for (int i = 0; i < `CORE_COUNT; i++)
    begin
      upper_mask[i] = (core_id_t'(i) > last_grant);
    end
  end

  assign upper_req = send_valid & upper_mask;
  assign upper_any = |upper_req;
  assign grant_any = |send_valid;

  // Search upward from the core after the last grant, then wrap to core 0
  always_comb
  begin
    if (upper_any)
    begin
      grant_idx = lowest_set(upper_req);
    end
    else
    begin
      grant_idx = lowest_set(send_valid);
    end
  end

  // Ready goes to the granted core only
  always_comb
  begin
    grant_onehot = '0;
    if (grant_any)
    begin
      grant_onehot[grant_idx] = 1'b1;
    end
  end

  assign send_ready = grant_onehot;

  // Pointer and output strobe
  // After reset core 15 counts as last granted, so core 0 wins first
  always_ff @(posedge core_clk)
  begin
    if (core_rst)
    begin
      last_grant   <= core_id_t'(`CORE_COUNT - 1);
      grant_valid  <= 1'b0;
      merged_valid <= 1'b0;
    end
    else
    begin
      grant_valid  <= grant_any;
      merged_valid <= grant_valid;
      if (grant_any)
      begin
        last_grant <= grant_idx;
      end
    end
  end

  // Message and sender captured on the transfer edge
  always_ff @(posedge core_clk)
  begin
    if (grant_any)
    begin
      grant_msg    <= send_msg[grant_idx];
      grant_sender <= grant_idx;
    end
  end

  // Merged message and sender index for the broadcast stage
  always_ff @(posedge core_clk)
  begin
    if (grant_valid)
    begin
      merged_msg    <= grant_msg;
      merged_sender <= grant_sender;
    end
  end

endmodule

`default_nettype wire

/* verilog/msg_broadcast.sv */
`timescale 1ns/1ns
`default_nettype none

module msg_broadcast
(
  input  wire                                core_clk,
  input  wire                                core_rst,

  // Merged stream from the arbiter
  input  wire                                merged_valid,
  input  wire  core_msg_pkg::core_msg_t      merged_msg,
  input  wire  core_msg_pkg::core_id_t       merged_sender,

  // Shared receive data and per-core receive strobes
  output core_msg_pkg::core_msg_t            recv_msg,
  output core_msg_pkg::core_mask_t           recv_valid
);

  import core_msg_pkg::*;

  // Sender as a one-hot mask
  core_mask_t sender_onehot;

  // Strobes for the next cycle
  core_mask_t recv_valid_next;

  always_comb
  begin
    sender_onehot = '0;
    sender_onehot[merged_sender] = 1'b1;
  end

  // Everyone hears the message except the core that sent it
  always_comb
  begin
    if (merged_valid)
    begin
      recv_valid_next = ~sender_onehot;
    end
    else
    begin
      recv_valid_next = '0;
    end
  end

  // Receive strobes, single cycle per message
  always_ff @(posedge core_clk)
  begin
    if (core_rst)
    begin
      recv_valid <= '0;
    end
    else
    begin
      recv_valid <= recv_valid_next;
    end
  end

  // Data bus shared by all cores, holds the last message between strobes
  always_ff @(posedge core_clk)
  begin
    if (merged_valid)
    begin
      recv_msg <= merged_msg;
    end
  end

endmodule

`default_nettype wire

/* verilog/core_msg_fabric.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_msg_macros.svh"

module core_msg_fabric
(
  input  wire                                              core_clk,
  input  wire                                              core_rst,

  // Messages leaving the cores
  input  wire  [`CORE_COUNT-1:0]                           msg_out_valid,
  input  wire  [`CORE_COUNT*core_msg_pkg::MSG_WIDTH-1:0]   msg_out_data,
  output logic [`CORE_COUNT-1:0]                           msg_out_ready,

  // Messages delivered to the cores
  output logic [core_msg_pkg::MSG_WIDTH-1:0]               msg_in_data,
  output logic [`CORE_COUNT-1:0]                           msg_in_valid
);

  import core_msg_pkg::*;

  // Sender side in package types
  core_mask_t send_valid;
  core_msg_t  send_msg [`CORE_COUNT];
  logic [`CORE_COUNT-1:0] send_ready;

  // Link between the two stages
  logic       merged_valid;
  core_msg_t  merged_msg;
  core_id_t   merged_sender;

  // Broadcast registers
  core_msg_t  recv_msg;
  core_mask_t recv_valid;

  assign send_valid = msg_out_valid;

  // Slice i of the flat vector is core i's message
  for (genvar i = 0; i < `CORE_COUNT; i++)
  begin : g_send_slice
    assign send_msg[i] = msg_out_data[i*MSG_WIDTH +: MSG_WIDTH];
  end

  // First stage, one grant per cycle
  msg_arbiter u_msg_arbiter
  (
    .core_clk      (core_clk),
    .core_rst      (core_rst),
    .send_valid    (send_valid),
    .send_msg      (send_msg),
    .send_ready    (send_ready),
    .merged_valid  (merged_valid),
    .merged_msg    (merged_msg),
    .merged_sender (merged_sender)
  );

  // Second stage, fan out to every core but the sender
  msg_broadcast u_msg_broadcast
  (
    .core_clk      (core_clk),
    .core_rst      (core_rst),
    .merged_valid  (merged_valid),
    .merged_msg    (merged_msg),
    .merged_sender (merged_sender),
    .recv_msg      (recv_msg),
    .recv_valid    (recv_valid)
  );

  assign msg_out_ready = send_ready;

  // Flatten the broadcast registers back to plain vectors
  assign msg_in_data  = recv_msg;
  assign msg_in_valid = recv_valid;

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
#(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
)
(
  output logic core_clk,
  output logic core_rst
);

  initial
  begin
    core_clk = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) core_clk = ~core_clk;
    end
  end

  // Release on a falling edge so the first active edge sees a clean reset
  initial
  begin
    core_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge core_clk);
    @(negedge core_clk);
    core_rst = 1'b0;
  end

endmodule

`default_nettype wire

/* test/core_msg_fabric_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_msg_macros.svh"

module core_msg_fabric_tb;

  import core_msg_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  // Rough cycle budget: reset, single, contend, back-to-back, random
  localparam int TEST_CYCLES  = (RESET_CYCLES + 3) + 10 + 24 + 14 + 240;
  localparam int WATCHDOG_NS  = (TEST_CYCLES * 2 + RESET_CYCLES) * CLK_PERIOD;

  logic core_clk;
  logic core_rst;

  logic [`CORE_COUNT-1:0]           msg_out_valid;
  logic [`CORE_COUNT*MSG_WIDTH-1:0] msg_out_data;
  logic [`CORE_COUNT-1:0]           msg_out_ready;
  logic [MSG_WIDTH-1:0]             msg_in_data;
  logic [`CORE_COUNT-1:0]           msg_in_valid;

  int seed;
  int errors;
  int tests_run;
  int tests_failed;
  int xfer_count;
  int strobe_count;

  // Reference model state
  int         last_ptr;
  core_mask_t granted;
  logic       s1_valid, s2_valid, out_valid;
  core_msg_t  s1_msg, s2_msg, out_msg;
  int         s1_sender, s2_sender, out_sender;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen
  (
    .core_clk (core_clk),
    .core_rst (core_rst)
  );

  core_msg_fabric DUT
  (
    .core_clk      (core_clk),
    .core_rst      (core_rst),
    .msg_out_valid (msg_out_valid),
    .msg_out_data  (msg_out_data),
    .msg_out_ready (msg_out_ready),
    .msg_in_data   (msg_in_data),
    .msg_in_valid  (msg_in_valid)
  );

  // Round-robin model, expected output two cycles after each transfer
  always @(posedge core_clk)
  begin : model
    core_mask_t exp_ready;
    int         exp_idx;
    int         cand;
    exp_ready = '0;
    exp_idx   = -1;
    if (core_rst)
    begin
      last_ptr  = `CORE_COUNT - 1;
      granted   = '0;
      s1_valid  = 1'b0;
      s2_valid  = 1'b0;
      out_valid = 1'b0;
    end
    else
    begin
      for (int j = 1; j <= `CORE_COUNT; j++)
      begin
        cand = (last_ptr + j) % `CORE_COUNT;
        if (exp_idx < 0 && msg_out_valid[cand])
        begin
          exp_idx = cand;
        end
      end
      if (exp_idx >= 0)
      begin
        exp_ready[exp_idx] = 1'b1;
      end
      assert (msg_out_ready == exp_ready)
      else
      begin
        $display("Fail at %0t ns: msg_out_ready %h, expected %h", $time, msg_out_ready,
                 exp_ready);
        errors++;
      end
      granted    = msg_out_ready & msg_out_valid;
      out_valid  = s2_valid;
      out_msg    = s2_msg;
      out_sender = s2_sender;
      s2_valid   = s1_valid;
      s2_msg     = s1_msg;
      s2_sender  = s1_sender;
      s1_valid   = (exp_idx >= 0);
      if (exp_idx >= 0)
      begin
        s1_msg    = msg_out_data[exp_idx*MSG_WIDTH +: MSG_WIDTH];
        s1_sender = exp_idx;
        last_ptr  = exp_idx;
        xfer_count++;
      end
    end
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge core_clk)
  begin : output_check
    core_mask_t exp_mask;
    exp_mask = '0;
    if (out_valid)
    begin
      exp_mask             = '1;
      exp_mask[out_sender] = 1'b0;
    end
    if (msg_in_valid != '0)
    begin
      strobe_count++;
    end
    assert (msg_in_valid == exp_mask)
    else
    begin
      if (exp_mask != '0 && msg_in_valid == '0)
        $display("At %0t ns the broadcast of the message from core %0d never arrived",
                 $time, out_sender);
      else if (exp_mask == '0)
        $display("At %0t ns a broadcast strobe appeared with no message due", $time);
      else
        $display("Fail at %0t ns: msg_in_valid %h, expected %h", $time, msg_in_valid,
                 exp_mask);
      errors++;
    end
    if (out_valid)
    begin
      assert (msg_in_data == out_msg)
      else
      begin
        $display("Fail at %0t ns: msg_in_data %h, expected %h", $time, msg_in_data, out_msg);
        errors++;
      end
    end
  end

  function automatic core_msg_t random_msg(input int core);
    core_msg_t m;
    m.kind = core[`MSG_TYPE_WIDTH-1:0];
    m.addr = dmem_addr_t'($random(seed));
    m.data = $random(seed);
    return m;
  endfunction

  task automatic load_msg(input int core, input core_msg_t m);
    msg_out_data[core*MSG_WIDTH +: MSG_WIDTH] = m;
    msg_out_valid[core]                       = 1'b1;
  endtask

  // Drop each valid bit once its core is granted
  task automatic wait_for_grants(input int limit, output int cycles);
    cycles = 0;
    while (msg_out_valid != '0 && cycles < limit)
    begin
      @(negedge core_clk);
      msg_out_valid = msg_out_valid & ~granted;
      cycles++;
    end
    assert (msg_out_valid == '0)
    else
    begin
      $display("Cores %h were still waiting for a grant after %0d cycles", msg_out_valid,
               limit);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int expected);
    assert (got == expected)
    else
    begin
      $display("Fail at %0t ns: %s was %0d, expected %0d", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors)
    begin
      $display("Test %s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic reset_state_test();
    int start_errors;
    start_errors = errors;
    repeat (RESET_CYCLES + 3)
    begin
      @(negedge core_clk);
      check_count("msg_in_valid", msg_in_valid, 0);
      check_count("msg_out_ready", msg_out_ready, 0);
    end
    report_test("reset state", start_errors);
  endtask

  task automatic single_sender_test();
    core_msg_t m;
    int        start_errors;
    int        cycles;
    int        waited;
    start_errors = errors;
    m            = random_msg(5);
    @(negedge core_clk);
    load_msg(5, m);
    #1;
    check_count("msg_out_ready", msg_out_ready, 32'h0020);
    wait_for_grants(4, cycles);
    waited = 0;
    while (msg_in_valid == '0 && waited < 5)
    begin
      @(negedge core_clk);
      waited++;
    end
    check_count("cycles from transfer to strobe", waited, 2);
    check_count("msg_in_valid", msg_in_valid, 32'hffdf);
    assert (msg_in_data == m)
    else
    begin
      $display("Fail at %0t ns: msg_in_data %h, expected %h", $time, msg_in_data, m);
      errors++;
    end
    @(negedge core_clk);
    check_count("msg_in_valid one cycle later", msg_in_valid, 0);
    report_test("single sender", start_errors);
  endtask

  task automatic all_contend_test();
    int start_errors;
    int strobes0;
    int cycles;
    start_errors = errors;
    strobes0     = strobe_count;
    @(negedge core_clk);
    for (int i = 0; i < `CORE_COUNT; i++)
    begin
      load_msg(i, random_msg(i));
    end
    wait_for_grants(40, cycles);
    check_count("cycles to grant all cores", cycles, `CORE_COUNT);
    repeat (3) @(negedge core_clk);
    check_count("broadcast strobes", strobe_count - strobes0, `CORE_COUNT);
    report_test("all sixteen contend", start_errors);
  endtask

  task automatic back_to_back_test();
    int start_errors;
    int strobes0;
    int sent;
    int cycles;
    start_errors = errors;
    strobes0     = strobe_count;
    @(negedge core_clk);
    load_msg(0, random_msg(0));
    sent   = 1;
    cycles = 0;
    while (msg_out_valid != '0 && cycles < 20)
    begin
      @(negedge core_clk);
      cycles++;
      check_count("core 0 grant", granted[0], 1);
      if (sent < 8)
      begin
        load_msg(0, random_msg(0));
        sent++;
      end
      else
      begin
        msg_out_valid[0] = 1'b0;
      end
    end
    check_count("cycles for eight messages", cycles, 8);
    repeat (3) @(negedge core_clk);
    check_count("broadcast strobes", strobe_count - strobes0, 8);
    report_test("back-to-back", start_errors);
  endtask

  task automatic random_traffic_test();
    int start_errors;
    int strobes0;
    int xfers0;
    int cycles;
    start_errors = errors;
    strobes0     = strobe_count;
    xfers0       = xfer_count;
    repeat (200)
    begin
      @(negedge core_clk);
      msg_out_valid = msg_out_valid & ~granted;
      for (int i = 0; i < `CORE_COUNT; i++)
      begin
        if (!msg_out_valid[i] && ($random(seed) & 3) == 0)
        begin
          load_msg(i, random_msg(i));
        end
      end
    end
    wait_for_grants(40, cycles);
    repeat (3) @(negedge core_clk);
    check_count("broadcast strobes", strobe_count - strobes0, xfer_count - xfers0);
    report_test("random traffic", start_errors);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("The tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    seed          = 46604;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    xfer_count    = 0;
    strobe_count  = 0;
    msg_out_valid = '0;
    msg_out_data  = '0;
    reset_state_test();
    single_sender_test();
    all_contend_test();
    back_to_back_test();
    random_traffic_test();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/core_msg_pkg.sv
verilog/msg_arbiter.sv
verilog/msg_broadcast.sv
verilog/core_msg_fabric.sv
test/tb_clock_gen.sv
test/core_msg_fabric_tb.sv

/* Bender.yml */
package:
  name: core_msg_fabric

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_msg_pkg.sv
      - verilog/msg_arbiter.sv
      - verilog/msg_broadcast.sv
      - verilog/core_msg_fabric.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock_gen.sv
      - test/core_msg_fabric_tb.sv
